//--- common/rr_storage_macros.svh
`ifndef RR_STORAGE_MACROS_SVH
`define RR_STORAGE_MACROS_SVH

// Channel layout of one logging unit, packed in fixed channel order
`define RR_CHANNEL_CNT 4
`define RR_CH0_WIDTH 8
`define RR_CH1_WIDTH 16
`define RR_CH2_WIDTH 4
`define RR_CH3_WIDTH 12

// Valid bitmap plus every channel payload
`define RR_UNIT_MAX_WIDTH 44
`define RR_LEN_WIDTH 6

// Memory side
`define RR_WORD_WIDTH 64
`define RR_ADDR_WIDTH 16
`define RR_BITCNT_WIDTH 32

`endif

//--- common/rr_stream_pkg.sv
`default_nettype none

`include "rr_storage_macros.svh"

package rr_stream_pkg;

  // A logging unit, LSB first: valid bitmap, then payloads of the set channels
  typedef logic [`RR_UNIT_MAX_WIDTH-1:0] unit_data_t;
  typedef logic [`RR_LEN_WIDTH-1:0] unit_len_t;
  typedef logic [`RR_WORD_WIDTH-1:0] mem_word_t;
  typedef logic [`RR_CHANNEL_CNT-1:0] valid_bitmap_t;

  // Unit length is the bitmap itself plus each channel whose valid bit is set
  function automatic unit_len_t unit_len_of(valid_bitmap_t bitmap);
    unit_len_t len;
    len = unit_len_t'(`RR_CHANNEL_CNT);
    if (bitmap[0]) len = len + unit_len_t'(`RR_CH0_WIDTH);
    if (bitmap[1]) len = len + unit_len_t'(`RR_CH1_WIDTH);
    if (bitmap[2]) len = len + unit_len_t'(`RR_CH2_WIDTH);
    if (bitmap[3]) len = len + unit_len_t'(`RR_CH3_WIDTH);
    return len;
  endfunction

endpackage

`default_nettype wire

//--- common/rr_csr_pkg.sv
`default_nettype none

`include "rr_storage_macros.svh"

package rr_csr_pkg;

  // Buffer addresses and sizes count 64-bit words
  typedef logic [`RR_ADDR_WIDTH-1:0] buf_addr_t;
  typedef logic [`RR_ADDR_WIDTH-1:0] buf_size_t;

  typedef logic [`RR_BITCNT_WIDTH-1:0] bit_count_t;

  // Bit 0 is write buffer full, bit 1 is replay done
  typedef logic [1:0] irq_reason_t;

  // Packer FSM: waiting for a buffer, packing, or padding out a partial word
  typedef enum logic [1:0] {
    PACK_IDLE,
    PACK_RUN,
    PACK_FLUSH
  } packer_state_t;

endpackage

`default_nettype wire

//--- trace_rw/rr_trace_packer.sv
`timescale 1ns/100ps
`default_nettype none

`include "rr_storage_macros.svh"

module rr_trace_packer
  import rr_stream_pkg::*, rr_csr_pkg::*;
(
  input  wire        clk,
  input  wire        rstn,
  input  wire        unit_valid,
  input  unit_data_t unit_data,
  input  unit_len_t  unit_len,
  output logic       unit_ready,
  input  wire        finish,
  input  wire        enable,
  output logic       word_valid,
  output mem_word_t  word_data,
  input  wire        word_ready
);

  localparam int WORD_W = `RR_WORD_WIDTH;
  localparam int ACC_W = `RR_WORD_WIDTH + `RR_UNIT_MAX_WIDTH;
  localparam int FILL_W = $clog2(ACC_W);

  packer_state_t state;
  logic [ACC_W-1:0] acc;
  logic [ACC_W-1:0] acc_kept;
  logic [ACC_W-1:0] acc_sum;
  logic [ACC_W-1:0] unit_ext;
  logic [FILL_W-1:0] fill;
  logic [FILL_W-1:0] fill_sum;
  logic slot_free;
  logic accept;
  logic word_done;
  logic flush_now;

  // The output register frees up in the same cycle its word is taken
  assign slot_free = !word_valid || word_ready;
  assign unit_ready = (state == PACK_RUN) && enable && slot_free && !finish;
  assign accept = unit_valid && unit_ready;

  // Bits above the fill are stale, so both the old and the new bits are masked
  assign unit_ext = ACC_W'(unit_data & ~({`RR_UNIT_MAX_WIDTH{1'b1}} << unit_len));
  assign acc_kept = acc & ~({ACC_W{1'b1}} << fill);
  assign acc_sum = acc_kept | (unit_ext << fill);
  assign fill_sum = fill + FILL_W'(unit_len);
  assign word_done = fill_sum >= FILL_W'(WORD_W);

  // A finish with a partial word emits it zero padded as soon as the slot is free
  assign flush_now = ((state == PACK_FLUSH) || ((state == PACK_RUN) && finish)) &&
                     slot_free && (fill != '0);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= PACK_IDLE;
      fill <= '0;
      word_valid <= 1'b0;
    end else begin
      if (word_valid && word_ready) begin
        word_valid <= 1'b0;
      end
      if (accept) begin
        if (word_done) begin
          word_valid <= 1'b1;
          fill <= fill_sum - FILL_W'(WORD_W);
        end else begin
          fill <= fill_sum;
        end
      end else if (flush_now) begin
        word_valid <= 1'b1;
        fill <= '0;
      end
      case (state)
        PACK_IDLE: if (enable) state <= PACK_RUN;
        PACK_RUN: if (finish && fill != '0) state <= PACK_FLUSH;
        // Hold off new units until the padded word has gone out
        PACK_FLUSH: if (fill == '0 && slot_free) state <= PACK_RUN;
        default: state <= PACK_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      if (word_done) begin
        word_data <= acc_sum[WORD_W-1:0];
        acc <= acc_sum >> WORD_W;
      end else begin
        acc <= acc_sum;
      end
    end else if (flush_now) begin
      word_data <= acc_kept[WORD_W-1:0];
    end
  end

  // The producer's length has to agree with the one the replay side will decode
  a_len_matches_bitmap: assert property (@(posedge clk) disable iff (!rstn)
    accept |-> unit_len == unit_len_of(unit_data[`RR_CHANNEL_CNT-1:0]));

  a_fill_in_range: assert property (@(posedge clk) disable iff (!rstn)
    accept |-> fill_sum <= FILL_W'(ACC_W - 1));

endmodule

`default_nettype wire

//--- trace_rw/rr_trace_unpacker.sv
`timescale 1ns/100ps
`default_nettype none

`include "rr_storage_macros.svh"

module rr_trace_unpacker
  import rr_stream_pkg::*;
(
  input  wire        clk,
  input  wire        rstn,
  input  wire        start,
  output logic       word_req,
  input  wire        word_valid,
  input  mem_word_t  word_data,
  output logic       unit_valid,
  output unit_data_t unit_data,
  output unit_len_t  unit_len,
  input  wire        unit_ready,
  input  wire        stop
);

  localparam int WORD_W = `RR_WORD_WIDTH;
  localparam int BUF_W = 2 * `RR_WORD_WIDTH;
  localparam int FILL_W = $clog2(BUF_W) + 1;

  logic [BUF_W-1:0] bit_buf;
  logic [BUF_W-1:0] buf_shift;
  logic [BUF_W-1:0] buf_next;
  logic [FILL_W-1:0] fill;
  logic [FILL_W-1:0] fill_shift;
  logic [FILL_W-1:0] fill_next;
  logic active;
  logic take;
  unit_len_t cur_len;

  // The head of the buffer always starts with the next unit's bitmap
  assign cur_len = unit_len_of(bit_buf[`RR_CHANNEL_CNT-1:0]);

  // With the fill below the bitmap width the decoded length is meaningless
  assign unit_valid = active && !stop && (fill >= FILL_W'(`RR_CHANNEL_CNT)) &&
                      (fill >= FILL_W'(cur_len));
  assign unit_data = bit_buf[`RR_UNIT_MAX_WIDTH-1:0] &
                     ~({`RR_UNIT_MAX_WIDTH{1'b1}} << cur_len);
  assign unit_len = cur_len;
  assign take = unit_valid && unit_ready;

  // Room for a whole word is guaranteed while the fill is at most one word
  assign word_req = active && (fill <= FILL_W'(WORD_W));

  always_comb begin
    buf_shift = bit_buf;
    fill_shift = fill;
    if (take) begin
      buf_shift = bit_buf >> cur_len;
      fill_shift = fill - FILL_W'(cur_len);
    end
    buf_next = buf_shift;
    fill_next = fill_shift;
    if (word_valid) begin
      buf_next = (buf_shift & ~({BUF_W{1'b1}} << fill_shift)) |
                 (BUF_W'(word_data) << fill_shift);
      fill_next = fill_shift + FILL_W'(WORD_W);
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      active <= 1'b0;
      fill <= '0;
    end else if (start) begin
      active <= 1'b1;
      fill <= '0;
    end else begin
      fill <= fill_next;
    end
  end

  always_ff @(posedge clk) begin
    bit_buf <= buf_next;
  end

  // A returning word has to land where the buffer still has room for all of it
  a_refill_fits: assert property (@(posedge clk) disable iff (!rstn)
    word_valid |-> fill_shift <= FILL_W'(WORD_W));

endmodule

`default_nettype wire

//--- trace_rw/rr_trace_rw.sv
`timescale 1ns/100ps
`default_nettype none

module rr_trace_rw
  import rr_stream_pkg::*, rr_csr_pkg::*;
(
  input  wire        clk,
  input  wire        rstn,
  input  wire        record_valid,
  input  unit_data_t record_data,
  input  unit_len_t  record_len,
  output logic       record_ready,
  output logic       replay_valid,
  output unit_data_t replay_data,
  output unit_len_t  replay_len,
  input  wire        replay_ready,
  output logic       mem_wr_valid,
  output buf_addr_t  mem_wr_addr,
  output mem_word_t  mem_wr_data,
  input  wire        mem_wr_ready,
  output logic       mem_rd_valid,
  output buf_addr_t  mem_rd_addr,
  input  wire        mem_rd_ready,
  input  wire        mem_rd_resp_valid,
  input  mem_word_t  mem_rd_resp_data,
  input  buf_addr_t  buf_addr,
  input  buf_size_t  buf_size,
  input  wire        write_buf_update,
  input  wire        read_buf_update,
  input  wire        record_finish,
  input  bit_count_t replay_bits,
  output bit_count_t record_bits,
  output bit_count_t rt_replay_bits,
  output logic       write_full,
  output logic       replay_done
);

  buf_addr_t wr_ptr, wr_end, rd_ptr, rd_end;
  bit_count_t replay_target;
  logic wr_started, rd_started, rd_outstanding, rd_active;
  logic pk_enable, pk_word_valid, wr_fire;
  logic word_req, rd_fire, unpk_stop;

  // Writes stop for good once the pointer reaches the end of the buffer
  assign pk_enable = wr_started && (wr_ptr != wr_end);
  assign mem_wr_valid = pk_word_valid && pk_enable;
  assign mem_wr_addr = wr_ptr;
  assign wr_fire = mem_wr_valid && mem_wr_ready;

  // Only one read in flight, so the unpacker never overflows its buffer
  assign mem_rd_valid = word_req && rd_started && !rd_outstanding && (rd_ptr != rd_end);
  assign mem_rd_addr = rd_ptr;
  assign rd_fire = mem_rd_valid && mem_rd_ready;
  assign unpk_stop = !rd_active || (rt_replay_bits == replay_target);

  rr_trace_packer u_packer (
    .clk(clk),
    .rstn(rstn),
    .unit_valid(record_valid),
    .unit_data(record_data),
    .unit_len(record_len),
    .unit_ready(record_ready),
    .finish(record_finish),
    .enable(pk_enable),
    .word_valid(pk_word_valid),
    .word_data(mem_wr_data),
    .word_ready(mem_wr_ready && pk_enable)
  );

  rr_trace_unpacker u_unpacker (
    .clk(clk),
    .rstn(rstn),
    .start(read_buf_update),
    .word_req(word_req),
    .word_valid(mem_rd_resp_valid),
    .word_data(mem_rd_resp_data),
    .unit_valid(replay_valid),
    .unit_data(replay_data),
    .unit_len(replay_len),
    .unit_ready(replay_ready),
    .stop(unpk_stop)
  );

  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_started <= 1'b0;
      wr_ptr <= '0;
      wr_end <= '0;
      record_bits <= '0;
      write_full <= 1'b0;
    end else begin
      write_full <= 1'b0;
      if (write_buf_update) begin
        wr_started <= 1'b1;
        wr_ptr <= buf_addr;
        wr_end <= buf_addr_t'(buf_addr + buf_size);
        record_bits <= '0;
      end else begin
        if (wr_fire) begin
          wr_ptr <= buf_addr_t'(wr_ptr + 1'b1);
          write_full <= buf_addr_t'(wr_ptr + 1'b1) == wr_end;
        end
        if (record_valid && record_ready) begin
          record_bits <= record_bits + bit_count_t'(record_len);
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rd_started <= 1'b0;
      rd_ptr <= '0;
      rd_end <= '0;
      rd_outstanding <= 1'b0;
      rd_active <= 1'b0;
      replay_target <= '0;
      rt_replay_bits <= '0;
      replay_done <= 1'b0;
    end else begin
      replay_done <= 1'b0;
      if (rd_fire) begin
        rd_outstanding <= 1'b1;
      end else if (mem_rd_resp_valid) begin
        rd_outstanding <= 1'b0;
      end
      if (read_buf_update) begin
        rd_started <= 1'b1;
        rd_ptr <= buf_addr;
        rd_end <= buf_addr_t'(buf_addr + buf_size);
        rd_active <= 1'b1;
        replay_target <= replay_bits;
        rt_replay_bits <= '0;
      end else begin
        if (rd_fire) begin
          rd_ptr <= buf_addr_t'(rd_ptr + 1'b1);
        end
        if (replay_valid && replay_ready) begin
          rt_replay_bits <= rt_replay_bits + bit_count_t'(replay_len);
        end
        // Done fires once, the cycle after the target count is reached
        if (rd_active && rt_replay_bits == replay_target) begin
          rd_active <= 1'b0;
          replay_done <= 1'b1;
        end
      end
    end
  end

  a_resp_has_request: assert property (@(posedge clk) disable iff (!rstn)
    mem_rd_resp_valid |-> rd_outstanding);

endmodule

`default_nettype wire

//--- logic/rr_irq_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module rr_irq_ctrl
  import rr_csr_pkg::*;
(
  input  wire         clk,
  input  wire         rstn,
  input  wire         write_full,
  input  wire         replay_done,
  output logic        irq_req,
  output irq_reason_t irq_reason,
  input  wire         irq_ack
);

  irq_reason_t new_reason;

  // Both event lines are single-cycle pulses
  assign new_reason = {replay_done, write_full};

  always_ff @(posedge clk) begin
    if (!rstn) begin
      irq_req <= 1'b0;
      irq_reason <= '0;
    end else if (irq_req && irq_ack) begin
      // An event landing on the ack cycle starts a fresh request
      irq_req <= |new_reason;
      irq_reason <= new_reason;
    end else if (|new_reason) begin
      irq_req <= 1'b1;
      irq_reason <= irq_reason | new_reason;
    end
  end

  a_ack_only_when_pending: assert property (@(posedge clk) disable iff (!rstn)
    irq_ack |-> irq_req);

endmodule

`default_nettype wire

//--- logic/rr_storage_backend.sv
`timescale 1ns/100ps
`default_nettype none

module rr_storage_backend
  import rr_stream_pkg::*, rr_csr_pkg::*;
(
  input  wire         clk,
  input  wire         rstn,
  input  wire         record_valid,
  input  unit_data_t  record_data,
  input  unit_len_t   record_len,
  output logic        record_ready,
  output logic        replay_valid,
  output unit_data_t  replay_data,
  output unit_len_t   replay_len,
  input  wire         replay_ready,
  output logic        mem_wr_valid,
  output buf_addr_t   mem_wr_addr,
  output mem_word_t   mem_wr_data,
  input  wire         mem_wr_ready,
  output logic        mem_rd_valid,
  output buf_addr_t   mem_rd_addr,
  input  wire         mem_rd_ready,
  input  wire         mem_rd_resp_valid,
  input  mem_word_t   mem_rd_resp_data,
  input  buf_addr_t   buf_addr,
  input  buf_size_t   buf_size,
  input  wire         write_buf_update,
  input  wire         read_buf_update,
  input  wire         record_finish,
  input  bit_count_t  replay_bits,
  output bit_count_t  record_bits,
  output bit_count_t  rt_replay_bits,
  output logic        irq_req,
  output irq_reason_t irq_reason,
  input  wire         irq_ack
);

  logic write_full;
  logic replay_done;

  rr_trace_rw u_trace_rw (
    .clk(clk),
    .rstn(rstn),
    .record_valid(record_valid),
    .record_data(record_data),
    .record_len(record_len),
    .record_ready(record_ready),
    .replay_valid(replay_valid),
    .replay_data(replay_data),
    .replay_len(replay_len),
    .replay_ready(replay_ready),
    .mem_wr_valid(mem_wr_valid),
    .mem_wr_addr(mem_wr_addr),
    .mem_wr_data(mem_wr_data),
    .mem_wr_ready(mem_wr_ready),
    .mem_rd_valid(mem_rd_valid),
    .mem_rd_addr(mem_rd_addr),
    .mem_rd_ready(mem_rd_ready),
    .mem_rd_resp_valid(mem_rd_resp_valid),
    .mem_rd_resp_data(mem_rd_resp_data),
    .buf_addr(buf_addr),
    .buf_size(buf_size),
    .write_buf_update(write_buf_update),
    .read_buf_update(read_buf_update),
    .record_finish(record_finish),
    .replay_bits(replay_bits),
    .record_bits(record_bits),
    .rt_replay_bits(rt_replay_bits),
    .write_full(write_full),
    .replay_done(replay_done)
  );

  // Buffer full and replay done share one request line
  rr_irq_ctrl u_irq_ctrl (
    .clk(clk),
    .rstn(rstn),
    .write_full(write_full),
    .replay_done(replay_done),
    .irq_req(irq_req),
    .irq_reason(irq_reason),
    .irq_ack(irq_ack)
  );

endmodule

`default_nettype wire

//--- testbench/tb_rr_storage_tasks.svh
// Unit length from the bitmap: 4 bitmap bits plus every set channel
function automatic unit_len_t expected_len(valid_bitmap_t bm);
  int total;
  total = `RR_CHANNEL_CNT;
  if (bm[0]) total += `RR_CH0_WIDTH;
  if (bm[1]) total += `RR_CH1_WIDTH;
  if (bm[2]) total += `RR_CH2_WIDTH;
  if (bm[3]) total += `RR_CH3_WIDTH;
  return unit_len_t'(total);
endfunction

// Builds a unit with random payloads, zero above its length
function automatic unit_data_t make_unit(valid_bitmap_t bm);
  unit_data_t data;
  int widths[4];
  int pos;
  widths[0] = `RR_CH0_WIDTH;
  widths[1] = `RR_CH1_WIDTH;
  widths[2] = `RR_CH2_WIDTH;
  widths[3] = `RR_CH3_WIDTH;
  data = '0;
  data[`RR_CHANNEL_CNT-1:0] = bm;
  pos = `RR_CHANNEL_CNT;
  for (int ch = 0; ch < `RR_CHANNEL_CNT; ch++) begin
    if (bm[ch]) begin
      for (int b = 0; b < widths[ch]; b++) begin
        data[pos] = 1'($urandom_range(0, 1));
        pos++;
      end
    end
  end
  return data;
endfunction

// Word k of the packed stream, padded with zeros past the last bit
function automatic mem_word_t expected_word(int k);
  mem_word_t w;
  int idx;
  w = '0;
  for (int b = 0; b < `RR_WORD_WIDTH; b++) begin
    idx = k * `RR_WORD_WIDTH + b;
    if (idx < ref_bits.size()) w[b] = ref_bits[idx];
  end
  return w;
endfunction

task automatic record_unit(valid_bitmap_t bm);
  unit_data_t d;
  unit_len_t l;
  d = make_unit(bm);
  l = expected_len(bm);
  for (int b = 0; b < int'(l); b++) ref_bits.push_back(d[b]);
  sent_data.push_back(d);
  sent_len.push_back(l);
  record_valid = 1'b1;
  record_data = d;
  record_len = l;
  @(negedge clk);
  while (!record_ready) @(negedge clk);
  @(posedge clk);
  #10;
  record_valid = 1'b0;
endtask

task automatic check_word(string what, mem_word_t got, mem_word_t exp);
  if (got !== exp)
    stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                            $time, what, got, exp));
endtask

task automatic check_addr(string what, buf_addr_t got, buf_addr_t exp);
  if (got !== exp)
    stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
                            $time, what, got, exp));
endtask

task automatic check_unit(string what, unit_data_t gd, unit_len_t gl,
                          unit_data_t ed, unit_len_t el);
  if (gd !== ed || gl !== el)
    stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %h/%0d, expected %h/%0d",
                            $time, what, gd, gl, ed, el));
endtask

task automatic check_count(string what, bit_count_t got, bit_count_t exp);
  if (got !== exp)
    stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                            $time, what, got, exp));
endtask

task automatic check_reason(irq_reason_t got, irq_reason_t exp);
  if (got !== exp)
    stop_on_error($sformatf("CHECK FAILED at %0t ns: irq_reason is %b, expected %b",
                            $time, got, exp));
endtask

task automatic check_flag(string what, logic got, logic exp);
  if (got !== exp)
    stop_on_error($sformatf("CHECK FAILED at %0t ns: %s is %b, expected %b",
                            $time, what, got, exp));
endtask

//--- testbench/tb_rr_storage_backend.sv
`timescale 1ns/100ps
`default_nettype none

`include "rr_storage_macros.svh"

module tb_rr_storage_backend
  import rr_stream_pkg::*, rr_csr_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;
  localparam int MEM_DEPTH = 4096;

  logic clk, rstn;
  logic record_valid, record_ready, replay_valid, replay_ready;
  unit_data_t record_data, replay_data;
  unit_len_t record_len, replay_len;
  logic mem_wr_valid, mem_wr_ready, mem_rd_valid, mem_rd_ready, mem_rd_resp_valid;
  buf_addr_t mem_wr_addr, mem_rd_addr, buf_addr;
  mem_word_t mem_wr_data, mem_rd_resp_data;
  buf_size_t buf_size;
  logic write_buf_update, read_buf_update, record_finish;
  bit_count_t replay_bits, record_bits, rt_replay_bits;
  logic irq_req, irq_ack;
  irq_reason_t irq_reason;

  mem_word_t mem [MEM_DEPTH];
  buf_addr_t rd_addr_q;
  int rd_delay;
  int cycle_count;
  logic bp_on;
  bit ref_bits[$];
  unit_data_t sent_data[$];
  unit_len_t sent_len[$];
  unit_data_t got_data[$];
  unit_len_t got_len[$];
  buf_addr_t wr_addr_log[$];
  mem_word_t wr_data_log[$];

  rr_storage_backend u_dut (.*);

  `include "tb_rr_storage_tasks.svh"

  always #50 clk = ~clk;

  // Handshakes are sampled at the falling edge, where every signal is settled
  always @(negedge clk) begin
    if (mem_wr_valid && mem_wr_ready) begin
      mem[int'(mem_wr_addr[11:0])] = mem_wr_data;
      wr_addr_log.push_back(mem_wr_addr);
      wr_data_log.push_back(mem_wr_data);
    end
    if (mem_rd_valid && mem_rd_ready) begin
      rd_addr_q = mem_rd_addr;
      rd_delay = $urandom_range(1, 3);
    end
    if (replay_valid && replay_ready) begin
      got_data.push_back(replay_data);
      got_len.push_back(replay_len);
    end
  end

  always @(posedge clk) begin
    #10;
    mem_rd_resp_valid = 1'b0;
    if (rd_delay > 0) begin
      rd_delay--;
      if (rd_delay == 0) begin
        mem_rd_resp_valid = 1'b1;
        mem_rd_resp_data = mem[int'(rd_addr_q[11:0])];
      end
    end
    mem_wr_ready = bp_on ? ($urandom_range(0, 3) != 0) : 1'b1;
    mem_rd_ready = bp_on ? ($urandom_range(0, 2) != 0) : 1'b1;
    replay_ready = bp_on ? ($urandom_range(0, 2) != 0) : 1'b1;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
      stop_on_error($sformatf("Timeout: the tests did not finish within %0d cycles",
                              TIMEOUT_CYCLES));
  end

  task automatic stop_on_error(string line);
    $display("%s", line);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic step();
    @(posedge clk);
    #10;
  endtask

  task automatic start_write(buf_addr_t addr, buf_size_t size);
    ref_bits.delete();
    sent_data.delete();
    sent_len.delete();
    wr_addr_log.delete();
    wr_data_log.delete();
    buf_addr = addr;
    buf_size = size;
    write_buf_update = 1'b1;
    step();
    write_buf_update = 1'b0;
  endtask

  task automatic start_replay(buf_addr_t addr, buf_size_t size, bit_count_t bits);
    got_data.delete();
    got_len.delete();
    buf_addr = addr;
    buf_size = size;
    replay_bits = bits;
    read_buf_update = 1'b1;
    step();
    read_buf_update = 1'b0;
  endtask

  task automatic finish_record();
    record_finish = 1'b1;
    step();
    record_finish = 1'b0;
  endtask

  task automatic ack_irq();
    irq_ack = 1'b1;
    step();
    irq_ack = 1'b0;
    step();
    check_flag("irq_req after ack", irq_req, 1'b0);
  endtask

  task automatic wait_irq();
    while (!irq_req) step();
  endtask

  // A fresh read_buf_update must not race a response still in flight
  task automatic wait_reads_idle();
    repeat (4) step();
    while (rd_delay != 0 || mem_rd_valid) step();
  endtask

  task automatic check_written(buf_addr_t base, int n_words);
    while (wr_data_log.size() < n_words) step();
    for (int k = 0; k < n_words; k++) begin
      check_addr("mem_wr_addr", wr_addr_log[k], buf_addr_t'(base + k));
      check_word("mem_wr_data", wr_data_log[k], expected_word(k));
    end
  endtask

  task automatic check_replayed();
    while (got_data.size() < sent_data.size()) step();
    for (int i = 0; i < sent_data.size(); i++)
      check_unit("replayed unit", got_data[i], got_len[i], sent_data[i], sent_len[i]);
  endtask

  task automatic test_record_packing();
    start_write(16'h0100, 16'd64);
    for (int i = 0; i < 20; i++) record_unit(valid_bitmap_t'(i * 7 + 1));
    finish_record();
    check_written(16'h0100, (ref_bits.size() + 63) / 64);
    check_count("record_bits", record_bits, bit_count_t'(ref_bits.size()));
  endtask

  task automatic test_replay_round_trip();
    start_replay(16'h0100, 16'd64, bit_count_t'(ref_bits.size()));
    check_replayed();
    wait_irq();
    check_count("rt_replay_bits", rt_replay_bits, bit_count_t'(ref_bits.size()));
    check_reason(irq_reason, 2'b10);
    ack_irq();
    wait_reads_idle();
  endtask

  // 44 + 44 + 40 bits fill exactly two words
  task automatic test_buffer_full();
    start_write(16'h0200, 16'd2);
    record_unit(4'hf);
    record_unit(4'hf);
    record_unit(4'hb);
    check_written(16'h0200, 2);
    wait_irq();
    check_reason(irq_reason, 2'b01);
    repeat (5) begin
      @(negedge clk);
      check_flag("record_ready", record_ready, 1'b0);
      check_flag("irq_req", irq_req, 1'b1);
    end
    step();
    ack_irq();
    check_reason(irq_reason, 2'b00);
  endtask

  task automatic test_reason_accumulation();
    start_write(16'h0210, 16'd1);
    record_unit(4'hf);
    record_unit(4'h2);
    check_written(16'h0210, 1);
    wait_irq();
    check_reason(irq_reason, 2'b01);
    start_replay(16'h0210, 16'd1, '0);
    repeat (3) step();
    check_reason(irq_reason, 2'b11);
    ack_irq();
    check_reason(irq_reason, 2'b00);
    wait_reads_idle();
  endtask

  task automatic test_random_stress();
    bp_on = 1'b1;
    start_write(16'h0300, 16'd256);
    for (int i = 0; i < 200; i++) begin
      record_unit(valid_bitmap_t'($urandom_range(0, 15)));
      if ($urandom_range(0, 3) == 0) step();
    end
    finish_record();
    check_written(16'h0300, (ref_bits.size() + 63) / 64);
    check_count("record_bits", record_bits, bit_count_t'(ref_bits.size()));
    start_replay(16'h0300, 16'd256, bit_count_t'(ref_bits.size()));
    check_replayed();
    wait_irq();
    check_count("rt_replay_bits", rt_replay_bits, bit_count_t'(ref_bits.size()));
    check_reason(irq_reason, 2'b10);
    ack_irq();
    bp_on = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h6e90));
    clk = 1'b0;
    rstn = 1'b0;
    record_valid = 1'b0;
    record_data = '0;
    record_len = '0;
    replay_ready = 1'b1;
    mem_wr_ready = 1'b1;
    mem_rd_ready = 1'b1;
    mem_rd_resp_valid = 1'b0;
    mem_rd_resp_data = '0;
    buf_addr = '0;
    buf_size = '0;
    write_buf_update = 1'b0;
    read_buf_update = 1'b0;
    record_finish = 1'b0;
    replay_bits = '0;
    irq_ack = 1'b0;
    bp_on = 1'b0;
    rd_delay = 0;
    cycle_count = 0;
    for (int i = 0; i < MEM_DEPTH; i++) mem[i] = {32'h5a00_0000 | i, 32'ha500_0000 ^ i};
    repeat (10) @(posedge clk);
    #10;
    rstn = 1'b1;
    step();
    test_record_packing();
    test_replay_round_trip();
    test_buffer_full();
    test_reason_accumulation();
    test_random_stress();
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+common
+incdir+testbench
common/rr_stream_pkg.sv
common/rr_csr_pkg.sv
trace_rw/rr_trace_packer.sv
trace_rw/rr_trace_unpacker.sv
trace_rw/rr_trace_rw.sv
logic/rr_irq_ctrl.sv
logic/rr_storage_backend.sv
testbench/tb_rr_storage_backend.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps \
  --top-module tb_rr_storage_backend -f src.f -o tb_sim &&
  ./obj_dir/tb_sim | tee /dev/stderr | grep -q "All tests passed!" &&
  echo "Simulation PASSED" ||
  { echo "Simulation FAILED"; exit 1; }
